// File: vlog.f
verilog/lsuPkg.sv
verilog/loadAligner.sv
verilog/storeFormatter.sv
verilog/loadStoreUnit.sv
verilog/dataRam.sv
verilog/lsuTop.sv
verif/lsuTopTb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - verilog/lsuPkg.sv
  - verilog/loadAligner.sv
  - verilog/storeFormatter.sv
  - verilog/loadStoreUnit.sv
  - verilog/dataRam.sv
  - verilog/lsuTop.sv
  - target: test
    files:
      - verif/lsuTopTb.sv

// File: verif/lsuTopTb.sv
`timescale 1ns/1ps
`default_nettype none

module lsuTopTb;

    localparam int timeoutCycles = 50;

    logic              clk;
    logic              rst;
    logic              flush;
    logic              fireStore;
    lsuPkg::memUop     uop;
    logic              busy;
    lsuPkg::commitInfo commit;
    lsuPkg::wbInfo     wb;

    // Byte model of the 1 KB physical space
    logic [7:0]        refMem [1024];
    logic [31:0]       rngState;
    int                errCount = 0;
    int                testErrBase = 0;
    int                passCount = 0;
    int                failCount = 0;
    int                commitCount = 0;
    int                wbCount = 0;
    lsuPkg::commitInfo lastCommit;
    lsuPkg::wbInfo     lastWb;
    lsuPkg::word       lastReqAddr;
    string             curTest;

    lsuTop #(
        .depthWords (256),
        .waitCycles (2)
    ) lsuTop_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .fireStore (fireStore),
        .uop       (uop),
        .busy      (busy),
        .commit    (commit),
        .wb        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Count the single-cycle pulses
    always @(negedge clk) begin
        if (!rst) begin
            if (commit.finish) begin
                commitCount++;
                lastCommit = commit;
            end
            if (wb.wen) begin
                wbCount++;
                lastWb = wb;
            end
            // Physical address of each memory transfer
            if (lsuTop_inst.memReq.valid && lsuTop_inst.memReady) begin
                lastReqAddr = lsuTop_inst.memReq.addr;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic lsuPkg::word nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic lsuPkg::word physOf(input lsuPkg::word va);
        if (va >= 32'h8000_0000 && va < 32'hA000_0000) begin
            return va - 32'h8000_0000;
        end else if (va >= 32'hA000_0000 && va < 32'hC000_0000) begin
            return va - 32'hA000_0000;
        end
        return va;
    endfunction

    function automatic void modelStore(input lsuPkg::memOp op, input lsuPkg::word va,
                                       input lsuPkg::word data);
        lsuPkg::word pa;
        logic [9:0]  idx;
        pa  = physOf(va);
        idx = pa[9:0];
        refMem[idx] = data[7:0];
        if (op != lsuPkg::SB) begin
            refMem[idx + 10'd1] = data[15:8];
        end
        if (op == lsuPkg::SW) begin
            refMem[idx + 10'd2] = data[23:16];
            refMem[idx + 10'd3] = data[31:24];
        end
    endfunction

    function automatic lsuPkg::word expectLoad(input lsuPkg::memOp op, input lsuPkg::word va);
        lsuPkg::word pa;
        logic [9:0]  idx;
        logic [7:0]  b0;
        logic [7:0]  b1;
        pa  = physOf(va);
        idx = pa[9:0];
        b0  = refMem[idx];
        b1  = refMem[idx + 10'd1];
        case (op)
            lsuPkg::LB:  return {{24{b0[7]}}, b0};
            lsuPkg::LBU: return {24'b0, b0};
            lsuPkg::LH:  return {{16{b1[7]}}, b1, b0};
            lsuPkg::LHU: return {16'b0, b1, b0};
            default:     return {refMem[idx + 10'd3], refMem[idx + 10'd2], b1, b0};
        endcase
    endfunction

    // Random id and dst and a random signed offset around the target address
    function automatic lsuPkg::memUop makeUop(input lsuPkg::memOp op, input lsuPkg::word addr,
                                              input lsuPkg::word data);
        lsuPkg::memUop u;
        lsuPkg::word   r;
        r           = nextRand();
        u           = '0;
        u.valid     = 1'b1;
        u.op        = op;
        u.id        = r[5:0];
        u.dst       = r[11:6];
        u.imm       = {{26{r[17]}}, r[17:12]};
        u.base      = addr - u.imm;
        u.storeData = data;
        return u;
    endfunction

    task automatic abortRun(input string reason);
        $display("ERROR: %s in test %s", reason, curTest);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic checkEq(input string what, input lsuPkg::word exp, input lsuPkg::word act);
        assert (exp === act) else begin
            $display("MISMATCH %s %s expected %h actual %h", curTest, what, exp, act);
            errCount++;
        end
    endtask

    task automatic startTest(input string name);
        curTest     = name;
        testErrBase = errCount;
    endtask

    task automatic endTest();
        if (errCount == testErrBase) begin
            $display("test %s: ok", curTest);
            passCount++;
        end else begin
            $display("test %s: %0d errors", curTest, errCount - testErrBase);
            failCount++;
        end
    endtask

    task automatic waitIdle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < timeoutCycles) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            abortRun("busy never fell");
        end else begin
            @(posedge clk);
        end
    endtask

    // Returns right after the acceptance edge
    task automatic sendUop(input lsuPkg::memUop u);
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < timeoutCycles) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            abortRun("unit stayed busy before issue");
        end else begin
            @(posedge clk);
            uop <= u;
            @(posedge clk);
            uop.valid <= 1'b0;
        end
    endtask

    task automatic issueStore(input lsuPkg::memOp op, input lsuPkg::word addr,
                              input lsuPkg::word data, input logic fire);
        lsuPkg::memUop u;
        int            c0;
        u  = makeUop(op, addr, data);
        c0 = commitCount;
        sendUop(u);
        checkEq("store finish count", c0 + 1, commitCount);
        checkEq("store finish id", u.id, lastCommit.id);
        checkEq("store exception", 0, lastCommit.exception);
        if (fire) begin
            @(posedge clk);
            fireStore <= 1'b1;
            @(posedge clk);
            fireStore <= 1'b0;
            waitIdle();
            modelStore(op, addr, data);
            checkEq("commits after fire", c0 + 1, commitCount);
        end
    endtask

    task automatic issueLoad(input lsuPkg::memOp op, input lsuPkg::word addr);
        lsuPkg::memUop u;
        lsuPkg::word   exp;
        int            c0;
        int            w0;
        u   = makeUop(op, addr, '0);
        exp = expectLoad(op, addr);
        c0  = commitCount;
        w0  = wbCount;
        sendUop(u);
        waitIdle();
        checkEq("load commit count", c0 + 1, commitCount);
        checkEq("load wb count", w0 + 1, wbCount);
        checkEq("load commit id", u.id, lastCommit.id);
        checkEq("load exception", 0, lastCommit.exception);
        checkEq("load rd", u.dst, lastWb.rd);
        checkEq("load data", exp, lastWb.wdata);
    endtask

    task automatic issueMisaligned(input lsuPkg::memOp op, input lsuPkg::word addr);
        lsuPkg::memUop u;
        lsuPkg::word   code;
        int            c0;
        int            w0;
        u    = makeUop(op, addr, nextRand());
        code = (op inside {lsuPkg::SB, lsuPkg::SH, lsuPkg::SW}) ? 32'd5 : 32'd4;
        c0   = commitCount;
        w0   = wbCount;
        sendUop(u);
        waitIdle();
        checkEq("exception commit count", c0 + 1, commitCount);
        checkEq("exception flag", 1, lastCommit.exception);
        checkEq("exception code", code, lastCommit.code);
        checkEq("badVAddr", addr, lastCommit.badVAddr);
        checkEq("exception id", u.id, lastCommit.id);
        checkEq("wb count", w0, wbCount);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        lsuPkg::word   addr;
        lsuPkg::word   data;
        lsuPkg::word   oldData;
        lsuPkg::memUop u;
        int            c0;
        int            w0;

        rst       = 1'b1;
        flush     = 1'b0;
        fireStore = 1'b0;
        uop       = '0;
        rngState  = 32'h12e25528;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        startTest("reset");
        checkEq("busy", 0, busy);
        checkEq("commit.finish", 0, commit.finish);
        checkEq("wb.wen", 0, wb.wen);
        checkEq("memReq.valid", 0, lsuTop_inst.memReq.valid);
        checkEq("memResp.valid", 0, lsuTop_inst.memResp.valid);
        endTest();

        startTest("storeLoadWord");
        for (int i = 0; i < 4; i++) begin
            data = nextRand();
            addr = 32'h100 + {data[27:22], 2'b00};
            data = nextRand();
            issueStore(lsuPkg::SW, addr, data, 1'b1);
            issueLoad(lsuPkg::LW, addr);
            checkEq("word readback", data, lastWb.wdata);
        end
        endTest();

        startTest("subWord");
        for (int off = 0; off < 4; off++) begin
            issueStore(lsuPkg::SB, 32'h200 + off, nextRand(), 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            issueStore(lsuPkg::SH, 32'h204 + off, nextRand(), 1'b1);
        end
        for (int off = 0; off < 4; off++) begin
            issueLoad(lsuPkg::LB, 32'h200 + off);
            issueLoad(lsuPkg::LBU, 32'h200 + off);
            issueLoad(lsuPkg::LB, 32'h204 + off);
        end
        for (int off = 0; off < 8; off += 2) begin
            issueLoad(lsuPkg::LH, 32'h200 + off);
            issueLoad(lsuPkg::LHU, 32'h200 + off);
        end
        endTest();

        startTest("misaligned");
        data = nextRand();
        issueStore(lsuPkg::SW, 32'h300, data, 1'b1);
        for (int off = 1; off < 4; off++) begin
            issueMisaligned(lsuPkg::LW, 32'h300 + off);
        end
        for (int off = 1; off < 4; off += 2) begin
            issueMisaligned(lsuPkg::LH, 32'h300 + off);
            issueMisaligned(lsuPkg::LHU, 32'h300 + off);
            issueMisaligned(lsuPkg::SH, 32'h300 + off);
            issueMisaligned(lsuPkg::SW, 32'h300 + off);
        end
        issueLoad(lsuPkg::LW, 32'h300);
        checkEq("memory unchanged", data, lastWb.wdata);
        endTest();

        startTest("segments");
        data = nextRand();
        addr = 32'h340 + {data[3:0], 2'b00};
        data = nextRand();
        issueStore(lsuPkg::SW, 32'h8000_0000 + addr, data, 1'b1);
        checkEq("kseg0 physical address", physOf(32'h8000_0000 + addr), lastReqAddr);
        issueLoad(lsuPkg::LW, 32'hA000_0000 + addr);
        checkEq("kseg1 physical address", physOf(32'hA000_0000 + addr), lastReqAddr);
        checkEq("kseg1 alias", data, lastWb.wdata);
        issueLoad(lsuPkg::LW, addr);
        checkEq("physical alias", data, lastWb.wdata);
        endTest();

        startTest("flush");
        oldData = nextRand();
        issueStore(lsuPkg::SW, 32'h380, oldData, 1'b1);
        // Store dropped while it waits for retirement
        issueStore(lsuPkg::SW, 32'h380, ~oldData, 1'b0);
        c0 = commitCount;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        waitIdle();
        checkEq("commits after store flush", c0, commitCount);
        issueLoad(lsuPkg::LW, 32'h380);
        checkEq("old data kept", oldData, lastWb.wdata);

        // Flush while the load request waits
        u  = makeUop(lsuPkg::LW, 32'h380, '0);
        c0 = commitCount;
        w0 = wbCount;
        sendUop(u);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        waitIdle();
        checkEq("commits after request flush", c0, commitCount);
        checkEq("wb after request flush", w0, wbCount);

        // Flush in the response cycle at waitCycles + 1 edges after acceptance
        u = makeUop(lsuPkg::LW, 32'h380, '0);
        sendUop(u);
        repeat (3) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        waitIdle();
        checkEq("commits after response flush", c0, commitCount);
        checkEq("wb after response flush", w0, wbCount);

        issueLoad(lsuPkg::LW, 32'h380);
        checkEq("load after flush", oldData, lastWb.wdata);
        endTest();

        $display("tests passed %0d failed %0d, check errors %0d", passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/lsuTop.sv
`timescale 1ns/1ps
`default_nettype none

module lsuTop #(
    parameter int depthWords = 256,
    parameter int waitCycles = 1
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          flush,
    input  wire logic          fireStore,
    input  wire lsuPkg::memUop uop,
    output logic               busy,
    output lsuPkg::commitInfo  commit,
    output lsuPkg::wbInfo      wb
);

    lsuPkg::memReq  memReq;
    lsuPkg::memResp memResp;
    logic           memReady;

    loadStoreUnit loadStoreUnit_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .fireStore (fireStore),
        .uop       (uop),
        .busy      (busy),
        .commit    (commit),
        .wb        (wb),
        .req       (memReq),
        .memReady  (memReady),
        .resp      (memResp)
    );

    dataRam #(
        .depthWords (depthWords),
        .waitCycles (waitCycles)
    ) dataRam_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (memReq),
        .memReady (memReady),
        .resp     (memResp)
    );

endmodule

`default_nettype wire

// File: verilog/dataRam.sv
`timescale 1ns/1ps
`default_nettype none

module dataRam #(
    parameter int depthWords = 256,
    parameter int waitCycles = 1
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire lsuPkg::memReq req,
    output logic               memReady,
    output lsuPkg::memResp     resp
);

    localparam int idxW = (depthWords > 1) ? $clog2(depthWords) : 1;
    localparam int cntW = (waitCycles > 0) ? $clog2(waitCycles + 1) : 1;

    lsuPkg::word     mem [depthWords];
    logic [cntW-1:0] waitCnt;
    logic [idxW-1:0] idx;
    logic            respValid;
    lsuPkg::word     respData;

    // Word address wraps at depthWords
    assign idx = idxW'((req.addr >> 2) % depthWords);

    ////////////////////////////////////////////////////////////////////////////
    // Accept delay
    ////////////////////////////////////////////////////////////////////////////

    assign memReady = req.valid && (waitCnt == cntW'(waitCycles));

    always_ff @(posedge clk) begin
        if (rst) begin
            waitCnt <= '0;
        end else if (!req.valid || memReady) begin
            waitCnt <= '0;
        end else begin
            waitCnt <= waitCnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (memReady && req.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req.strobe[lane]) begin
                    mem[idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            respValid <= 1'b0;
        end else begin
            respValid <= memReady && !req.write;
        end
    end

    always_ff @(posedge clk) begin
        if (memReady && !req.write) begin
            respData <= mem[idx];
        end
    end

    assign resp = '{valid: respValid, rdata: respData};

endmodule

`default_nettype wire

// File: verilog/loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           flush,
    input  wire logic           fireStore,
    input  wire lsuPkg::memUop  uop,
    output logic                busy,
    output lsuPkg::commitInfo   commit,
    output lsuPkg::wbInfo       wb,
    output lsuPkg::memReq       req,
    input  wire logic           memReady,
    input  wire lsuPkg::memResp resp
);

    typedef enum logic [2:0] {
        sIdle,
        sException,
        sLoadReq,
        sLoadResp,
        sStoreWait,
        sStoreFire,
        sRecover
    } lsuState;

    lsuState           state;
    lsuState           nextState;
    lsuPkg::memUop     cur;
    lsuPkg::word       inAddr;
    lsuPkg::word       effAddr;
    lsuPkg::word       physAddr;
    logic              accept;
    logic              inMisaligned;
    lsuPkg::word       loadData;
    lsuPkg::byteStrobe storeStrobe;
    lsuPkg::word       storeData;

    function automatic logic isStore(input lsuPkg::memOp op);
        return op inside {lsuPkg::SB, lsuPkg::SH, lsuPkg::SW};
    endfunction

    function automatic logic misaligned(input lsuPkg::memOp op, input logic [1:0] low);
        case (op)
            lsuPkg::LW, lsuPkg::SW: begin
                return low != 2'b00;
            end
            lsuPkg::LH, lsuPkg::LHU, lsuPkg::SH: begin
                return low[0];
            end
            default: begin
                return 1'b0;
            end
        endcase
    endfunction

    // kseg0 and kseg1 both alias the low 512 MB
    function automatic lsuPkg::word toPhys(input lsuPkg::word va);
        if (va[31:30] == 2'b10) begin
            return {3'b000, va[28:0]};
        end
        return va;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Acceptance and address
    ////////////////////////////////////////////////////////////////////////////

    assign inAddr       = uop.base + uop.imm;
    assign inMisaligned = misaligned(uop.op, inAddr[1:0]);
    assign accept       = (state == sIdle) && uop.valid && !flush;

    assign effAddr  = cur.base + cur.imm;
    assign physAddr = toPhys(effAddr);

    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= uop;
        end
    end

    loadAligner loadAligner_inst (
        .op     (cur.op),
        .offset (effAddr[1:0]),
        .raw    (resp.rdata),
        .result (loadData)
    );

    storeFormatter storeFormatter_inst (
        .op     (cur.op),
        .offset (physAddr[1:0]),
        .data   (cur.storeData),
        .strobe (storeStrobe),
        .wdata  (storeData)
    );

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            sIdle: begin
                if (accept) begin
                    if (inMisaligned) begin
                        nextState = sException;
                    end else if (isStore(uop.op)) begin
                        nextState = sStoreWait;
                    end else begin
                        nextState = sLoadReq;
                    end
                end
            end
            sException: begin
                nextState = sIdle;
            end
            sLoadReq: begin
                if (flush) begin
                    nextState = sIdle;
                end else if (memReady) begin
                    nextState = sLoadResp;
                end
            end
            sLoadResp: begin
                // A response in the flush cycle is simply dropped
                if (resp.valid) begin
                    nextState = sIdle;
                end else if (flush) begin
                    nextState = sRecover;
                end
            end
            sStoreWait: begin
                if (flush) begin
                    nextState = sIdle;
                end else if (fireStore) begin
                    nextState = sStoreFire;
                end
            end
            sStoreFire: begin
                // Past commit, flush no longer applies
                if (memReady) begin
                    nextState = sIdle;
                end
            end
            sRecover: begin
                if (resp.valid) begin
                    nextState = sIdle;
                end
            end
            default: begin
                nextState = sIdle;
            end
        endcase
    end

    always_comb begin
        busy             = 1'b1;
        req.valid        = 1'b0;
        req.write        = 1'b0;
        req.addr         = {physAddr[31:2], 2'b00};
        req.strobe       = storeStrobe;
        req.wdata        = storeData;
        commit.finish    = 1'b0;
        commit.id        = cur.id;
        commit.exception = 1'b0;
        commit.code      = isStore(cur.op) ? lsuPkg::excAdES : lsuPkg::excAdEL;
        commit.badVAddr  = effAddr;
        wb.wen           = 1'b0;
        wb.rd            = cur.dst;
        wb.wdata         = loadData;
        case (state)
            sIdle: begin
                busy = 1'b0;
                // Stores finish at acceptance, the write waits for retirement
                if (accept && isStore(uop.op) && !inMisaligned) begin
                    commit.finish = 1'b1;
                    commit.id     = uop.id;
                end
            end
            sException: begin
                commit.finish    = !flush;
                commit.exception = !flush;
            end
            sLoadReq: begin
                req.valid = !flush;
            end
            sLoadResp: begin
                if (resp.valid) begin
                    busy          = 1'b0;
                    commit.finish = !flush;
                    wb.wen        = !flush;
                end
            end
            sStoreFire: begin
                busy      = !memReady;
                req.valid = 1'b1;
                req.write = 1'b1;
                req.addr  = physAddr;
            end
            sRecover: begin
                busy = !resp.valid;
            end
            default: begin
                busy = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/storeFormatter.sv
`timescale 1ns/1ps
`default_nettype none

module storeFormatter (
    input  wire lsuPkg::memOp op,
    input  wire logic [1:0]   offset,
    input  wire lsuPkg::word  data,
    output lsuPkg::byteStrobe strobe,
    output lsuPkg::word       wdata
);

    logic [4:0] byteShift;

    assign byteShift = {offset, 3'b000};

    always_comb begin
        case (op)
            lsuPkg::SB: begin
                strobe = 4'b0001 << offset;
                wdata  = {24'b0, data[7:0]} << byteShift;
            end
            lsuPkg::SH: begin
                if (offset[1]) begin
                    strobe = 4'b1100;
                    wdata  = {data[15:0], 16'b0};
                end else begin
                    strobe = 4'b0011;
                    wdata  = {16'b0, data[15:0]};
                end
            end
            lsuPkg::SW: begin
                strobe = 4'b1111;
                wdata  = data;
            end
            default: begin
                // Loads never write
                strobe = 4'b0000;
                wdata  = data;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/loadAligner.sv
`timescale 1ns/1ps
`default_nettype none

module loadAligner (
    input  wire lsuPkg::memOp op,
    input  wire logic [1:0]   offset,
    input  wire lsuPkg::word  raw,
    output lsuPkg::word       result
);

    logic [7:0]  selByte;
    logic [15:0] selHalf;

    assign selByte = raw[8*offset +: 8];
    // Halfword lane only depends on bit 1
    assign selHalf = raw[16*offset[1] +: 16];

    always_comb begin
        case (op)
            lsuPkg::LB: begin
                result = {{24{selByte[7]}}, selByte};
            end
            lsuPkg::LBU: begin
                result = {24'b0, selByte};
            end
            lsuPkg::LH: begin
                result = {{16{selHalf[15]}}, selHalf};
            end
            lsuPkg::LHU: begin
                result = {16'b0, selHalf};
            end
            default: begin
                result = raw;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/lsuPkg.sv
`default_nettype none

package lsuPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word;
    typedef logic [5:0]  robId;
    typedef logic [5:0]  physReg;
    typedef logic [3:0]  byteStrobe;
    typedef logic [4:0]  excCode;

    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } memOp;

    // Address error on load / on store
    localparam excCode excAdEL = 5'd4;
    localparam excCode excAdES = 5'd5;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic   valid;
        memOp   op;
        robId   id;
        physReg dst;
        word    base;
        word    imm;
        word    storeData;
    } memUop;

    // addr is physical
    typedef struct packed {
        logic      valid;
        logic      write;
        word       addr;
        byteStrobe strobe;
        word       wdata;
    } memReq;

    typedef struct packed {
        logic valid;
        word  rdata;
    } memResp;

    typedef struct packed {
        logic   finish;
        robId   id;
        logic   exception;
        excCode code;
        word    badVAddr;
    } commitInfo;

    typedef struct packed {
        logic   wen;
        physReg rd;
        word    wdata;
    } wbInfo;

endpackage

`default_nettype wire
